/* source/mci_pkg.sv */
`default_nettype none

package mci_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int USER_WIDTH = 32;

    localparam int KB = 1024;

    //////////////////////////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////////////////////////
    // Register space is 4 KB
    localparam int MCI_REG_MIN_ADDR_WIDTH = 12;
    // Each mailbox is 64 bytes, sixteen words
    localparam int MBOX_CSR_ADDR_WIDTH = 6;

    localparam logic [ADDR_WIDTH-1:0] MCI_REG_START_ADDR  = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] MBOX0_START_ADDR    = 32'h0008_0000;
    localparam logic [ADDR_WIDTH-1:0] MBOX1_START_ADDR    = 32'h0009_0000;
    localparam logic [ADDR_WIDTH-1:0] MCU_SRAM_START_ADDR = 32'h0020_0000;

    // Fixed window ends, SRAM end depends on its size parameter
    localparam logic [ADDR_WIDTH-1:0] MCI_REG_END_ADDR =
        MCI_REG_START_ADDR + (32'h1 << MCI_REG_MIN_ADDR_WIDTH) - 32'h1;
    localparam logic [ADDR_WIDTH-1:0] MBOX0_END_ADDR =
        MBOX0_START_ADDR + (32'h1 << MBOX_CSR_ADDR_WIDTH) - 32'h1;
    localparam logic [ADDR_WIDTH-1:0] MBOX1_END_ADDR =
        MBOX1_START_ADDR + (32'h1 << MBOX_CSR_ADDR_WIDTH) - 32'h1;

    //////////////////////////////////////////////////////////////////////
    // Register and mailbox word offsets
    //////////////////////////////////////////////////////////////////////
    localparam int REG_IDX_WIDTH  = MCI_REG_MIN_ADDR_WIDTH - 2;
    localparam int MBOX_IDX_WIDTH = MBOX_CSR_ADDR_WIDTH - 2;

    localparam logic [REG_IDX_WIDTH-1:0] REG_ID_OFFSET      = 'd0;
    localparam logic [REG_IDX_WIDTH-1:0] REG_SCRATCH_OFFSET = 'd1;
    localparam logic [REG_IDX_WIDTH-1:0] REG_CTRL_OFFSET    = 'd2;

    localparam logic [DATA_WIDTH-1:0] MCI_ID_VALUE = 32'h4d43_4901;

    // Word 0 is the lock, words 1..15 hold data
    localparam logic [MBOX_IDX_WIDTH-1:0] MBOX_LOCK_OFFSET = 'd0;
    localparam logic [MBOX_IDX_WIDTH-1:0] MBOX_DATA_BASE   = 'd1;
    localparam int MBOX_DEPTH = 2 ** MBOX_IDX_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // Request and response payloads
    //////////////////////////////////////////////////////////////////////
    // 97 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  write;
        logic [USER_WIDTH-1:0] user;
    } cif_req_t;

    // 34 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic                  hold;
        logic                  error;
    } cif_resp_t;

endpackage

`default_nettype wire

/* source/mci_axi_sub_decode.sv */
`default_nettype none
`timescale 1ns/100ps

module mci_axi_sub_decode
    import mci_pkg::*;
#(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    // Requester side
    input  wire logic                  dv,
    input  wire cif_req_t              soc_req_data,
    output cif_resp_t                  soc_resp,

    // Target side
    output logic                       reg_dv,
    output logic                       mbox0_dv,
    output logic                       mbox1_dv,
    output logic                       sram_dv,
    output cif_req_t                   tgt_req_data,
    input  wire cif_resp_t             reg_resp,
    input  wire cif_resp_t             mbox0_resp,
    input  wire cif_resp_t             mbox1_resp,
    input  wire cif_resp_t             sram_resp,

    // Privileged user straps
    input  wire logic [USER_WIDTH-1:0] strap_mcu_lsu_axi_user,
    input  wire logic [USER_WIDTH-1:0] strap_mcu_ifu_axi_user,
    input  wire logic [USER_WIDTH-1:0] strap_clp_axi_user,

    // Privilege strobes
    output logic                       mcu_lsu_req,
    output logic                       mcu_ifu_req,
    output logic                       mcu_req,
    output logic                       clp_req,
    output logic                       soc_req
);

    // SRAM window follows the configured size
    localparam logic [ADDR_WIDTH-1:0] MCU_SRAM_END_ADDR =
        MCU_SRAM_START_ADDR + ADDR_WIDTH'(MCU_SRAM_SIZE_KB * KB) - 32'h1;
    // Bits needed to cover the whole map
    localparam int MCI_INTERNAL_ADDR_WIDTH = $clog2(MCU_SRAM_END_ADDR);

    logic [MCI_INTERNAL_ADDR_WIDTH-1:0] int_addr;
    logic                               req_miss;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////
    // Low bits only for register and SRAM windows
    always_comb int_addr = soc_req_data.addr[MCI_INTERNAL_ADDR_WIDTH-1:0];

    always_comb reg_dv   = dv & (int_addr inside {[MCI_REG_START_ADDR:MCI_REG_END_ADDR]});
    always_comb sram_dv  = dv & (int_addr inside {[MCU_SRAM_START_ADDR:MCU_SRAM_END_ADDR]});
    // Mailboxes use the full address
    always_comb mbox0_dv = dv & (soc_req_data.addr inside {[MBOX0_START_ADDR:MBOX0_END_ADDR]});
    always_comb mbox1_dv = dv & (soc_req_data.addr inside {[MBOX1_START_ADDR:MBOX1_END_ADDR]});

    // Same request goes to every target
    always_comb tgt_req_data = soc_req_data;

    //////////////////////////////////////////////////////////////////////
    // Response merge
    //////////////////////////////////////////////////////////////////////
    // Nothing hit
    always_comb req_miss = dv & ~(reg_dv | sram_dv | mbox0_dv | mbox1_dv);

    always_comb begin
        // Read data from the selected target, zero otherwise
        if (sram_dv) begin
            soc_resp.rdata = sram_resp.rdata;
        end else if (reg_dv) begin
            soc_resp.rdata = reg_resp.rdata;
        end else if (mbox0_dv) begin
            soc_resp.rdata = mbox0_resp.rdata;
        end else if (mbox1_dv) begin
            soc_resp.rdata = mbox1_resp.rdata;
        end else begin
            soc_resp.rdata = '0;
        end

        // Only the selected target may stall
        soc_resp.hold = (sram_dv  & sram_resp.hold)  |
                        (reg_dv   & reg_resp.hold)   |
                        (mbox0_dv & mbox0_resp.hold) |
                        (mbox1_dv & mbox1_resp.hold);

        // Target error or miss
        soc_resp.error = (sram_dv  & sram_resp.error)  |
                         (reg_dv   & reg_resp.error)   |
                         (mbox0_dv & mbox0_resp.error) |
                         (mbox1_dv & mbox1_resp.error) |
                         req_miss;
    end

    //////////////////////////////////////////////////////////////////////
    // Privileged user classification
    //////////////////////////////////////////////////////////////////////
    // Exact match against straps
    always_comb mcu_lsu_req = dv & (soc_req_data.user == strap_mcu_lsu_axi_user);
    always_comb mcu_ifu_req = dv & (soc_req_data.user == strap_mcu_ifu_axi_user);
    always_comb mcu_req     = mcu_lsu_req | mcu_ifu_req;
    always_comb clp_req     = dv & (soc_req_data.user == strap_clp_axi_user);
    // Everything else is plain SoC traffic
    always_comb soc_req     = dv & ~(mcu_req | clp_req);

endmodule

`default_nettype wire

/* source/mci_reg_block.sv */
`default_nettype none
`timescale 1ns/100ps

module mci_reg_block
    import mci_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     dv,
    input  wire cif_req_t req_data,
    input  wire logic     priv_req,
    output cif_resp_t     resp
);

    logic [REG_IDX_WIDTH-1:0] word_idx;
    logic [DATA_WIDTH-1:0]    scratch_q;
    logic [DATA_WIDTH-1:0]    ctrl_q;
    logic [DATA_WIDTH-1:0]    rd_val;
    logic                     acc_err;
    logic                     wr_ok;

    // Word offset inside the 4 KB window
    always_comb word_idx = req_data.addr[MCI_REG_MIN_ADDR_WIDTH-1:2];

    //////////////////////////////////////////////////////////////////////
    // Read mux and access check
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rd_val  = '0;
        acc_err = 1'b0;
        case (word_idx)
            REG_ID_OFFSET: begin
                rd_val  = MCI_ID_VALUE;
                // ID is read only
                acc_err = req_data.write;
            end
            REG_SCRATCH_OFFSET: begin
                rd_val = scratch_q;
            end
            REG_CTRL_OFFSET: begin
                rd_val  = ctrl_q;
                // Protected, privileged users only
                acc_err = req_data.write & ~priv_req;
            end
            default: begin
                // Unimplemented offset
                acc_err = 1'b1;
            end
        endcase
    end

    always_comb wr_ok = dv & req_data.write & ~acc_err;

    //////////////////////////////////////////////////////////////////////
    // Register updates
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scratch_q <= '0;
            ctrl_q    <= '0;
        end else if (wr_ok) begin
            if (word_idx == REG_SCRATCH_OFFSET) begin
                scratch_q <= req_data.wdata;
            end
            if (word_idx == REG_CTRL_OFFSET) begin
                ctrl_q <= req_data.wdata;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response, never stalls
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        resp.rdata = (dv & ~req_data.write & ~acc_err) ? rd_val : '0;
        resp.hold  = 1'b0;
        resp.error = dv & acc_err;
    end

endmodule

`default_nettype wire

/* source/mci_mbox.sv */
`default_nettype none
`timescale 1ns/100ps

module mci_mbox
    import mci_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     dv,
    input  wire cif_req_t req_data,
    output cif_resp_t     resp
);

    logic [MBOX_IDX_WIDTH-1:0] word_idx;
    logic                      is_lock;
    logic                      lock_q;
    logic                      rd_pend_q;
    logic                      rd_start;
    logic                      wr_err;
    logic                      data_wr;
    logic [DATA_WIDTH-1:0]     rdata_q;
    // Data words only, lock lives in its own flop
    logic [DATA_WIDTH-1:0]     data_mem [MBOX_DATA_BASE:MBOX_DEPTH-1];

    always_comb word_idx = req_data.addr[MBOX_CSR_ADDR_WIDTH-1:2];
    always_comb is_lock  = (word_idx == MBOX_LOCK_OFFSET);

    // First cycle of a read
    always_comb rd_start = dv & ~req_data.write & ~rd_pend_q;

    // Data writes need the lock held
    always_comb wr_err  = dv & req_data.write & ~is_lock & ~lock_q;
    always_comb data_wr = dv & req_data.write & ~is_lock & lock_q;

    //////////////////////////////////////////////////////////////////////
    // Lock and read pending state
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock_q    <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            // One wait cycle per read
            if (rd_start) begin
                rd_pend_q <= 1'b1;
            end else if (rd_pend_q) begin
                rd_pend_q <= 1'b0;
            end
            // Reading the lock word grabs it, once per read
            if (rd_start & is_lock) begin
                lock_q <= 1'b1;
            end
            // Any lock write releases
            if (dv & req_data.write & is_lock) begin
                lock_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data array and read capture
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (data_wr) begin
            data_mem[word_idx] <= req_data.wdata;
        end
        if (rd_start) begin
            // Lock read returns the state before acquisition
            if (is_lock) begin
                rdata_q <= {{(DATA_WIDTH-1){1'b0}}, lock_q};
            end else begin
                rdata_q <= data_mem[word_idx];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        resp.rdata = rd_pend_q ? rdata_q : '0;
        resp.hold  = rd_start;
        resp.error = wr_err;
    end

endmodule

`default_nettype wire

/* source/mcu_sram.sv */
`default_nettype none
`timescale 1ns/100ps

module mcu_sram
    import mci_pkg::*;
#(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     dv,
    input  wire cif_req_t req_data,
    output cif_resp_t     resp
);

    // Words of DATA_WIDTH bits
    localparam int SRAM_DEPTH  = (MCU_SRAM_SIZE_KB * KB) / (DATA_WIDTH / 8);
    localparam int SRAM_IDX_W  = $clog2(SRAM_DEPTH);

    logic [SRAM_IDX_W-1:0] word_idx;
    logic                  rd_start;
    logic                  rd_pend_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic [DATA_WIDTH-1:0] mem [SRAM_DEPTH];

    // Byte address to word index
    always_comb word_idx = req_data.addr[SRAM_IDX_W+1:2];
    always_comb rd_start = dv & ~req_data.write & ~rd_pend_q;

    //////////////////////////////////////////////////////////////////////
    // Read pending flag
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_start;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Array
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        // Writes finish in the same cycle
        if (dv & req_data.write) begin
            mem[word_idx] <= req_data.wdata;
        end
        // Registered read
        if (rd_start) begin
            rdata_q <= mem[word_idx];
        end
    end

    // No error source here
    always_comb begin
        resp.rdata = rd_pend_q ? rdata_q : '0;
        resp.hold  = rd_start;
        resp.error = 1'b0;
    end

endmodule

`default_nettype wire

/* source/mci_top.sv */
`default_nettype none
`timescale 1ns/100ps

module mci_top
    import mci_pkg::*;
#(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  dv,
    input  wire cif_req_t              req_data,
    output cif_resp_t                  resp,
    input  wire logic [USER_WIDTH-1:0] strap_mcu_lsu_axi_user,
    input  wire logic [USER_WIDTH-1:0] strap_mcu_ifu_axi_user,
    input  wire logic [USER_WIDTH-1:0] strap_clp_axi_user,
    output logic                       mcu_lsu_req,
    output logic                       mcu_ifu_req,
    output logic                       mcu_req,
    output logic                       clp_req,
    output logic                       soc_req
);

    // Per target valids
    logic      reg_dv;
    logic      mbox0_dv;
    logic      mbox1_dv;
    logic      sram_dv;
    // Shared request, per target responses
    cif_req_t  tgt_req_data;
    cif_resp_t reg_resp;
    cif_resp_t mbox0_resp;
    cif_resp_t mbox1_resp;
    cif_resp_t sram_resp;
    // Protected register write enable
    logic      priv_req;

    always_comb priv_req = mcu_req | clp_req;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////
    mci_axi_sub_decode #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) u_decode (
        .dv                     (dv),
        .soc_req_data           (req_data),
        .soc_resp               (resp),
        .reg_dv                 (reg_dv),
        .mbox0_dv               (mbox0_dv),
        .mbox1_dv               (mbox1_dv),
        .sram_dv                (sram_dv),
        .tgt_req_data           (tgt_req_data),
        .reg_resp               (reg_resp),
        .mbox0_resp             (mbox0_resp),
        .mbox1_resp             (mbox1_resp),
        .sram_resp              (sram_resp),
        .strap_mcu_lsu_axi_user (strap_mcu_lsu_axi_user),
        .strap_mcu_ifu_axi_user (strap_mcu_ifu_axi_user),
        .strap_clp_axi_user     (strap_clp_axi_user),
        .mcu_lsu_req            (mcu_lsu_req),
        .mcu_ifu_req            (mcu_ifu_req),
        .mcu_req                (mcu_req),
        .clp_req                (clp_req),
        .soc_req                (soc_req)
    );

    //////////////////////////////////////////////////////////////////////
    // Targets
    //////////////////////////////////////////////////////////////////////
    mci_reg_block u_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv       (reg_dv),
        .req_data (tgt_req_data),
        .priv_req (priv_req),
        .resp     (reg_resp)
    );

    // Two identical mailboxes
    mci_mbox u_mbox0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv       (mbox0_dv),
        .req_data (tgt_req_data),
        .resp     (mbox0_resp)
    );

    mci_mbox u_mbox1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv       (mbox1_dv),
        .req_data (tgt_req_data),
        .resp     (mbox1_resp)
    );

    mcu_sram #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) u_sram (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv       (sram_dv),
        .req_data (tgt_req_data),
        .resp     (sram_resp)
    );

endmodule

`default_nettype wire

/* tb/mci_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module mci_checker
    import mci_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    // DUT ports under watch
    input  wire logic       dv,
    input  wire cif_resp_t  resp,
    input  wire logic       mcu_lsu_req,
    input  wire logic       mcu_ifu_req,
    input  wire logic       mcu_req,
    input  wire logic       clp_req,
    input  wire logic       soc_req,
    // Expected values of the current table entry
    input  wire cif_resp_t  exp_resp,
    input  wire logic [1:0] exp_class,
    input  wire logic [1:0] exp_wait,
    output int              err_cnt
);

    // Class codes: 0 soc, 1 mcu lsu, 2 mcu ifu, 3 clp
    int errors = 0;
    int hold_cnt;

    assign err_cnt = errors;

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sample before the edge updates any flop
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            hold_cnt <= 0;
        end else if (dv && resp.hold) begin
            // Wait state, count it
            hold_cnt <= hold_cnt + 1;
        end else if (dv) begin
            // Completing cycle
            compare("rdata", resp.rdata, exp_resp.rdata);
            compare("error", {31'b0, resp.error}, {31'b0, exp_resp.error});
            compare("hold_cycles", hold_cnt, {30'b0, exp_wait});
            // Strobes from the user classification rule
            compare("mcu_lsu_req", {31'b0, mcu_lsu_req}, {31'b0, exp_class == 2'd1});
            compare("mcu_ifu_req", {31'b0, mcu_ifu_req}, {31'b0, exp_class == 2'd2});
            compare("mcu_req", {31'b0, mcu_req},
                    {31'b0, (exp_class == 2'd1) || (exp_class == 2'd2)});
            compare("clp_req", {31'b0, clp_req}, {31'b0, exp_class == 2'd3});
            compare("soc_req", {31'b0, soc_req}, {31'b0, exp_class == 2'd0});
            hold_cnt <= 0;
        end
    end

endmodule

`default_nettype wire

/* tb/mci_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module mci_tb
    import mci_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;
    localparam int TB_SRAM_KB     = 4;
    localparam int SRAM_WORDS     = TB_SRAM_KB * KB / 4;

    // Strap values and one plain user
    localparam logic [USER_WIDTH-1:0] USER_LSU = 32'h0000_0011;
    localparam logic [USER_WIDTH-1:0] USER_IFU = 32'h0000_0022;
    localparam logic [USER_WIDTH-1:0] USER_CLP = 32'h0000_0033;
    localparam logic [USER_WIDTH-1:0] USER_SOC = 32'h0000_0044;

    localparam logic [1:0] CLS_SOC = 2'd0;
    localparam logic [1:0] CLS_LSU = 2'd1;
    localparam logic [1:0] CLS_IFU = 2'd2;
    localparam logic [1:0] CLS_CLP = 2'd3;

    // Byte addresses, word offset times four
    localparam logic [ADDR_WIDTH-1:0] A_ID      = MCI_REG_START_ADDR + 32'h0;
    localparam logic [ADDR_WIDTH-1:0] A_SCRATCH = MCI_REG_START_ADDR + 32'h4;
    localparam logic [ADDR_WIDTH-1:0] A_CTRL    = MCI_REG_START_ADDR + 32'h8;
    localparam logic [ADDR_WIDTH-1:0] A_UNMAPPED = 32'h0010_0000;

    typedef struct packed {
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [USER_WIDTH-1:0] user;
        logic [DATA_WIDTH-1:0] exp_rdata;
        logic                  exp_error;
        logic [1:0]            exp_class;
        logic [1:0]            exp_wait;
    } entry_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  dv;
    cif_req_t              req_data;
    cif_resp_t             resp;
    logic [USER_WIDTH-1:0] strap_lsu;
    logic [USER_WIDTH-1:0] strap_ifu;
    logic [USER_WIDTH-1:0] strap_clp;
    logic                  mcu_lsu_req;
    logic                  mcu_ifu_req;
    logic                  mcu_req;
    logic                  clp_req;
    logic                  soc_req;
    cif_resp_t             exp_resp;
    logic [1:0]            exp_class;
    logic [1:0]            exp_wait;
    int                    err_cnt;
    int                    timeout_cnt;
    entry_t                tbl[$];
    // Random payloads, fixed before the run
    logic [DATA_WIDTH-1:0] rnd_scr;
    logic [DATA_WIDTH-1:0] rnd_ctrl;
    logic [DATA_WIDTH-1:0] rnd_sram;
    logic [DATA_WIDTH-1:0] rnd_mb0;
    logic [DATA_WIDTH-1:0] rnd_mb1;
    logic [ADDR_WIDTH-1:0] sram_addr;

    always #2 clk = ~clk;

    mci_top #(
        .MCU_SRAM_SIZE_KB (TB_SRAM_KB)
    ) dut0 (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .dv                     (dv),
        .req_data               (req_data),
        .resp                   (resp),
        .strap_mcu_lsu_axi_user (strap_lsu),
        .strap_mcu_ifu_axi_user (strap_ifu),
        .strap_clp_axi_user     (strap_clp),
        .mcu_lsu_req            (mcu_lsu_req),
        .mcu_ifu_req            (mcu_ifu_req),
        .mcu_req                (mcu_req),
        .clp_req                (clp_req),
        .soc_req                (soc_req)
    );

    mci_checker chk0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .dv          (dv),
        .resp        (resp),
        .mcu_lsu_req (mcu_lsu_req),
        .mcu_ifu_req (mcu_ifu_req),
        .mcu_req     (mcu_req),
        .clp_req     (clp_req),
        .soc_req     (soc_req),
        .exp_resp    (exp_resp),
        .exp_class   (exp_class),
        .exp_wait    (exp_wait),
        .err_cnt     (err_cnt)
    );

    task automatic add_entry(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [31:0] user, input logic [31:0] rdata,
                             input logic err, input logic [1:0] cls, input logic [1:0] wt);
        tbl.push_back('{wr, addr, wdata, user, rdata, err, cls, wt});
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////
    task automatic build_table();
        // Register block, no wait states
        add_entry(1'b0, A_ID, '0, USER_SOC, MCI_ID_VALUE, 1'b0, CLS_SOC, 2'd0);
        add_entry(1'b1, A_SCRATCH, rnd_scr, USER_SOC, '0, 1'b0, CLS_SOC, 2'd0);
        add_entry(1'b0, A_SCRATCH, '0, USER_LSU, rnd_scr, 1'b0, CLS_LSU, 2'd0);
        // Protected ctrl, rejected then accepted
        add_entry(1'b1, A_CTRL, rnd_ctrl, USER_SOC, '0, 1'b1, CLS_SOC, 2'd0);
        add_entry(1'b0, A_CTRL, '0, USER_SOC, '0, 1'b0, CLS_SOC, 2'd0);
        add_entry(1'b1, A_CTRL, rnd_ctrl, USER_CLP, '0, 1'b0, CLS_CLP, 2'd0);
        add_entry(1'b0, A_CTRL, '0, USER_IFU, rnd_ctrl, 1'b0, CLS_IFU, 2'd0);
        // SRAM, read waits one cycle
        add_entry(1'b1, sram_addr, rnd_sram, USER_SOC, '0, 1'b0, CLS_SOC, 2'd0);
        add_entry(1'b0, sram_addr, '0, USER_LSU, rnd_sram, 1'b0, CLS_LSU, 2'd1);
        // Mailbox 0 lock sequence
        add_entry(1'b0, MBOX0_START_ADDR, '0, USER_SOC, 32'd0, 1'b0, CLS_SOC, 2'd1);
        add_entry(1'b0, MBOX0_START_ADDR, '0, USER_SOC, 32'd1, 1'b0, CLS_SOC, 2'd1);
        add_entry(1'b1, MBOX0_START_ADDR + 32'h4, rnd_mb0, USER_CLP, '0, 1'b0, CLS_CLP, 2'd0);
        add_entry(1'b0, MBOX0_START_ADDR + 32'h4, '0, USER_SOC, rnd_mb0, 1'b0, CLS_SOC, 2'd1);
        // Mailbox 1 still free
        add_entry(1'b0, MBOX1_START_ADDR, '0, USER_IFU, 32'd0, 1'b0, CLS_IFU, 2'd1);
        // Release mailbox 0, data writes now rejected
        add_entry(1'b1, MBOX0_START_ADDR, '0, USER_SOC, '0, 1'b0, CLS_SOC, 2'd0);
        add_entry(1'b1, MBOX0_START_ADDR + 32'h8, rnd_mb1, USER_SOC, '0, 1'b1, CLS_SOC, 2'd0);
        // Mailbox 1 keeps its own lock
        add_entry(1'b1, MBOX1_START_ADDR + 32'hc, rnd_mb1, USER_SOC, '0, 1'b0, CLS_SOC, 2'd0);
        add_entry(1'b0, MBOX1_START_ADDR + 32'hc, '0, USER_SOC, rnd_mb1, 1'b0, CLS_SOC, 2'd1);
        add_entry(1'b0, MBOX0_START_ADDR, '0, USER_LSU, 32'd0, 1'b0, CLS_LSU, 2'd1);
        // Miss in the map
        add_entry(1'b0, A_UNMAPPED, '0, USER_SOC, '0, 1'b1, CLS_SOC, 2'd0);
        add_entry(1'b1, A_UNMAPPED, rnd_scr, USER_CLP, '0, 1'b1, CLS_CLP, 2'd0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drive loop
    //////////////////////////////////////////////////////////////////////
    initial begin
        int unsigned seed_ret;
        int          wait_cnt;
        bit          done;
        seed_ret    = $urandom(32'hcb20_a165);
        rst_n       = 1'b0;
        dv          = 1'b0;
        req_data    = '0;
        strap_lsu   = USER_LSU;
        strap_ifu   = USER_IFU;
        strap_clp   = USER_CLP;
        exp_resp    = '0;
        exp_class   = CLS_SOC;
        exp_wait    = 2'd0;
        timeout_cnt = 0;
        rnd_scr     = $urandom;
        rnd_ctrl    = $urandom;
        rnd_sram    = $urandom;
        rnd_mb0     = $urandom;
        rnd_mb1     = $urandom;
        sram_addr   = MCU_SRAM_START_ADDR + (($urandom % SRAM_WORDS) << 2);
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (tbl[i]) begin
            @(negedge clk);
            dv        = 1'b1;
            req_data  = '{addr: tbl[i].addr, wdata: tbl[i].wdata,
                          write: tbl[i].write, user: tbl[i].user};
            exp_resp  = '{rdata: tbl[i].exp_rdata, hold: 1'b0, error: tbl[i].exp_error};
            exp_class = tbl[i].exp_class;
            exp_wait  = tbl[i].exp_wait;
            // Completion is the first edge with hold low
            done = 1'b0;
            for (wait_cnt = 0; wait_cnt < TIMEOUT_CYCLES && !done; wait_cnt++) begin
                @(posedge clk);
                if (!resp.hold) begin
                    done = 1'b1;
                end
            end
            if (!done) begin
                $display("Timeout: entry %0d still held after %0d cycles", i, TIMEOUT_CYCLES);
                timeout_cnt++;
            end
            // Idle cycle between entries
            @(negedge clk);
            dv = 1'b0;
        end

        repeat (2) @(posedge clk);
        $display("Errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/mci_pkg.sv
source/mci_axi_sub_decode.sv
source/mci_reg_block.sv
source/mci_mbox.sv
source/mcu_sram.sv
source/mci_top.sv
tb/mci_checker.sv
tb/mci_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module mci_tb \
    -f flist.f \
    -o mci_sim

./obj_dir/mci_sim > sim.log 2>&1 || true
cat sim.log

# Verdict comes from the log
if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
